// File: lpif_slave_pkg.sv
/*
  Shared widths and types for the LPIF slave link
  One clock domain; credit logic, logic-link FIFO and user markers are absent
  Gen2 moves a word per beat on both lanes, gen1 uses two lane 0 beats
*/
package lpif_slave_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int lane_width_c   = 40;
  localparam int stream_width_c = 42;
  localparam int delay_width_c  = 16;
  // Payload bits carried by one gen1 half beat
  localparam int gen1_half_c    = 21;

  ////////////////////////////////////////
  // Stream word and bring-up config

  // LPIF stream word, state on top
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [31:0] data;
    logic        dvalid;
    logic        crc;
    logic        crc_valid;
    logic        valid;
  } lpif_stream_t;

  // Sequencer delays in clk_wr cycles
  typedef struct packed {
    logic [delay_width_c-1:0] delay_x;
    logic [delay_width_c-1:0] delay_y;
    logic [delay_width_c-1:0] delay_z;
  } lpif_delay_cfg_t;

  ////////////////////////////////////////
  // PHY beat

  typedef struct packed {
    logic [lane_width_c-1:0] lane1;
    logic [lane_width_c-1:0] lane0;
  } lpif_phy_pair_t;

  // Gen2 view of a beat
  // Marker is the top bit of lane 1, strobe is bit 0 of lane 0
  typedef struct packed {
    logic                                     marker;
    logic [2*lane_width_c-stream_width_c-3:0] spare;
    logic [stream_width_c-1:0]                payload;
    logic                                     strobe;
  } lpif_gen2_fields_t;

  // Same 80 bits seen as raw lanes or as gen2 fields
  typedef union packed {
    lpif_phy_pair_t    lanes;
    lpif_gen2_fields_t fields;
  } lpif_phy_beat_u;

  // Debug word, count is sent words on TX and strobe errors on RX
  typedef struct packed {
    logic [13:0] reserved;
    logic        tx_online_delay;
    logic        rx_online_delay;
    logic [15:0] count;
  } lpif_debug_status_t;

endpackage

// File: lpif_auto_sync.sv
/*
  Three chained bring-up delays: TX online, RX online, downstream release
  A stage rises on the edge that ends the delay-th cycle of its enable
  A delay of zero behaves as one; a drop of tx_online or rx_online clears
  every later stage on the next edge
*/
module lpif_auto_sync import lpif_slave_pkg::*; (
  input  logic            clk_wr,
  input  logic            reset,
  input  logic            tx_online,
  input  logic            rx_online,
  input  lpif_delay_cfg_t delay_cfg,
  output logic            tx_online_delay,
  output logic            rx_online_delay,
  output logic            rx_release
);

  // Stage 0 TX online, stage 1 RX online, stage 2 release
  logic [2:0]                    stage_en;
  logic [2:0]                    stage_done;
  logic [2:0][delay_width_c-1:0] stage_delay;
  logic [2:0][delay_width_c-1:0] stage_cnt;

  ////////////////////////////////////////
  // Stage enables

  assign stage_delay = {delay_cfg.delay_z, delay_cfg.delay_y, delay_cfg.delay_x};

  // TX side only needs its own request
  assign stage_en[0] = tx_online;
  // RX waits for TX to be up, raw inputs included so a drop acts at once
  assign stage_en[1] = tx_online & rx_online & stage_done[0];
  // Release follows RX online
  assign stage_en[2] = stage_en[1] & stage_done[1];

  ////////////////////////////////////////
  // Delay counters

  always_ff @(posedge clk_wr) begin
    logic [delay_width_c-1:0] cnt_next;
    if (reset) begin
      stage_cnt  <= '0;
      stage_done <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        // At least one, so a zero delay still takes a cycle
        cnt_next = stage_cnt[i] + 1'b1;
        if (!stage_en[i]) begin
          stage_cnt[i]  <= '0;
          stage_done[i] <= 1'b0;
        end else if (!stage_done[i]) begin
          stage_cnt[i] <= cnt_next;
          if (cnt_next >= stage_delay[i]) begin
            stage_done[i] <= 1'b1;
          end
        end
      end
    end
  end

  // Done levels are the stage outputs
  assign tx_online_delay = stage_done[0];
  assign rx_online_delay = stage_done[1];
  assign rx_release      = stage_done[2];

endmodule

// File: lpif_phy_tx.sv
/*
  Upstream framer onto two PHY lanes, no back-pressure
  Gen2 sends ustrm one cycle later on both lanes with strobe and marker set
  Gen1 samples every other cycle and sends low then high half on lane 0,
  so the word offered in between is dropped
*/
module lpif_phy_tx import lpif_slave_pkg::*; (
  input  logic               clk_wr,
  input  logic               reset,
  input  logic               m_gen2_mode,
  input  logic               tx_online_delay,
  input  logic               rx_online_delay,
  input  lpif_stream_t       ustrm,
  output lpif_phy_pair_t     tx_phy,
  output lpif_debug_status_t tx_debug_status
);

  lpif_phy_beat_u         beat_d;
  lpif_phy_beat_u         beat_q;
  // Gen1 phase, 0 sends the low half and samples ustrm
  logic                   phase_q;
  logic [gen1_half_c-1:0] high_half_q;
  logic [15:0]            sent_cnt_q;
  logic                   word_done;

  // A word is complete on every gen2 beat or on the gen1 high half
  assign word_done = tx_online_delay & (m_gen2_mode | phase_q);

  ////////////////////////////////////////
  // Beat build

  always_comb begin
    beat_d = '0;
    if (tx_online_delay) begin
      if (m_gen2_mode) begin
        // Whole word in one beat
        beat_d.fields.marker  = 1'b1;
        beat_d.fields.payload = ustrm;
        beat_d.fields.strobe  = 1'b1;
      end else begin
        // Lane 0 only, marker flags the first half
        beat_d.lanes.lane0[0]              = 1'b1;
        beat_d.lanes.lane0[lane_width_c-1] = !phase_q;
        if (!phase_q) begin
          beat_d.lanes.lane0[gen1_half_c:1] = ustrm[gen1_half_c-1:0];
        end else begin
          beat_d.lanes.lane0[gen1_half_c:1] = high_half_q;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Registers

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      beat_q     <= '0;
      phase_q    <= 1'b0;
      sent_cnt_q <= '0;
    end else begin
      beat_q  <= beat_d;
      // Toggles only while gen1 is online
      phase_q <= tx_online_delay & !m_gen2_mode & !phase_q;
      // Wraps at 16 bits
      if (word_done) begin
        sent_cnt_q <= sent_cnt_q + 1'b1;
      end
    end
  end

  // Upper half held for the second gen1 beat
  always_ff @(posedge clk_wr) begin
    if (tx_online_delay && !m_gen2_mode && !phase_q) begin
      high_half_q <= ustrm[stream_width_c-1:gen1_half_c];
    end
  end

  assign tx_phy = beat_q.lanes;

  always_comb begin
    tx_debug_status                 = '0;
    tx_debug_status.tx_online_delay = tx_online_delay;
    tx_debug_status.rx_online_delay = rx_online_delay;
    tx_debug_status.count           = sent_cnt_q;
  end

endmodule

// File: lpif_phy_rx.sv
/*
  Downstream deframer from two PHY lanes, one register stage to dstrm
  Gen1 needs a marker beat followed by a non-marker beat to rebuild a word
  A beat without strobe while RX is online bumps a saturating error count
  dstrm reads zero until both RX online and release are high
*/
module lpif_phy_rx import lpif_slave_pkg::*; (
  input  logic               clk_wr,
  input  logic               reset,
  input  logic               m_gen2_mode,
  input  logic               tx_online_delay,
  input  logic               rx_online_delay,
  input  logic               rx_release,
  input  lpif_phy_pair_t     rx_phy,
  output lpif_stream_t       dstrm,
  output lpif_debug_status_t rx_debug_status
);

  lpif_phy_beat_u         beat_in;
  logic                   strobe;
  logic                   marker;
  logic [gen1_half_c-1:0] gen1_half;
  logic [gen1_half_c-1:0] low_half_q;
  // Low half waiting for its partner
  logic                   low_valid_q;
  logic                   word_load;
  lpif_stream_t           word_d;
  lpif_stream_t           word_q;
  logic                   beat_err;
  logic [15:0]            err_cnt_q;

  ////////////////////////////////////////
  // Beat decode

  assign beat_in.lanes = rx_phy;
  // Strobe sits at bit 0 of lane 0 in both modes
  assign strobe    = beat_in.fields.strobe;
  // Gen1 marker and payload live on lane 0
  assign marker    = beat_in.lanes.lane0[lane_width_c-1];
  assign gen1_half = beat_in.lanes.lane0[gen1_half_c:1];

  assign beat_err = rx_online_delay & !strobe;

  always_comb begin
    word_load = 1'b0;
    word_d    = beat_in.fields.payload;
    if (rx_online_delay && strobe) begin
      if (m_gen2_mode) begin
        word_load = 1'b1;
      end else if (!marker && low_valid_q) begin
        // Second half completes the word
        word_load = 1'b1;
        word_d    = {gen1_half, low_half_q};
      end
    end
  end

  ////////////////////////////////////////
  // Control state

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      low_valid_q <= 1'b0;
      err_cnt_q   <= '0;
    end else begin
      // Any bad or out-of-mode beat drops a pending low half
      if (!rx_online_delay || m_gen2_mode || !strobe) begin
        low_valid_q <= 1'b0;
      end else begin
        low_valid_q <= marker;
      end
      // Saturating
      if (beat_err && err_cnt_q != '1) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Word registers

  always_ff @(posedge clk_wr) begin
    // Cleared while offline, held on strobe errors
    if (!rx_online_delay) begin
      word_q <= '0;
    end else if (word_load) begin
      word_q <= word_d;
    end
    if (marker && strobe) begin
      low_half_q <= gen1_half;
    end
  end

  assign dstrm = (rx_online_delay && rx_release) ? word_q : '0;

  always_comb begin
    rx_debug_status                 = '0;
    rx_debug_status.tx_online_delay = tx_online_delay;
    rx_debug_status.rx_online_delay = rx_online_delay;
    rx_debug_status.count           = err_cnt_q;
  end

endmodule

// File: lpif_slave_top.sv
/*
  LPIF slave top, single clock clk_wr, synchronous active-high reset
  No credits and no FIFO; words move as plain valid levels
  Loopback latency is 2 cycles in gen2 and 3 cycles in gen1
*/
module lpif_slave_top import lpif_slave_pkg::*; (
  input  logic               clk_wr,
  input  logic               reset,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic               m_gen2_mode,
  input  lpif_delay_cfg_t    delay_cfg,
  input  lpif_stream_t       ustrm,
  input  lpif_phy_pair_t     rx_phy,
  output lpif_phy_pair_t     tx_phy,
  output lpif_stream_t       dstrm,
  output lpif_debug_status_t tx_debug_status,
  output lpif_debug_status_t rx_debug_status
);

  // Sequencer levels
  logic tx_online_delay;
  logic rx_online_delay;
  logic rx_release;

  ////////////////////////////////////////
  // Bring-up

  lpif_auto_sync auto_sync_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_cfg       (delay_cfg),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_release      (rx_release)
  );

  ////////////////////////////////////////
  // PHY halves

  // Upstream words onto the lanes
  lpif_phy_tx phy_tx_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .m_gen2_mode     (m_gen2_mode),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .ustrm           (ustrm),
    .tx_phy          (tx_phy),
    .tx_debug_status (tx_debug_status)
  );

  // Downstream words back from the lanes
  lpif_phy_rx phy_rx_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .m_gen2_mode     (m_gen2_mode),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_release      (rx_release),
    .rx_phy          (rx_phy),
    .dstrm           (dstrm),
    .rx_debug_status (rx_debug_status)
  );

endmodule

// File: lpif_slave_properties.sv
/*
  Concurrent checks for the LPIF slave, bound into lpif_slave_top
  Models the bring-up timing itself from delay_cfg and the online inputs
  Data checks assume a clean gen1 pair or gen2 beat on rx_phy
  err_count is read by the testbench at the end of the run
*/
module lpif_slave_checker import lpif_slave_pkg::*; (
  input logic               clk_wr,
  input logic               reset,
  input logic               tx_online,
  input logic               rx_online,
  input logic               m_gen2_mode,
  input lpif_delay_cfg_t    delay_cfg,
  input lpif_stream_t       ustrm,
  input lpif_phy_pair_t     rx_phy,
  input lpif_phy_pair_t     tx_phy,
  input lpif_stream_t       dstrm,
  input lpif_debug_status_t tx_debug_status,
  input lpif_debug_status_t rx_debug_status
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned err_count = 0;

  // Consecutive enabled cycles per stage
  int unsigned tx_run;
  int unsigned rx_run;
  int unsigned rel_run;
  logic exp_tx;
  logic exp_rx;
  logic exp_rel;
  // ustrm_h[k] is ustrm as sampled k edges back
  lpif_stream_t [3:1] ustrm_h;
  lpif_stream_t       dstrm_d1;
  lpif_phy_pair_t     tx_phy_d1;
  logic [15:0]        cnt_d1;
  logic               bad_d1;
  logic [15:0]        tx_cnt_d1;
  logic               gen2_d1;
  // Beat on tx_phy that closes a whole word
  logic               tx_word_end;

  // Zero delay counts as one cycle
  function automatic int unsigned at_least_one(logic [15:0] d);
    return (d == '0) ? 32'd1 : {16'd0, d};
  endfunction

  ////////////////////////////////////////
  // Reference model

  assign exp_tx  = tx_run >= at_least_one(delay_cfg.delay_x);
  assign exp_rx  = rx_run >= at_least_one(delay_cfg.delay_y);
  assign exp_rel = rel_run >= at_least_one(delay_cfg.delay_z);

  // Strobed gen2 beat or strobed gen1 high half
  assign tx_word_end = tx_phy.lane0[0] & (gen2_d1 | !tx_phy.lane0[lane_width_c-1]);

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_run  <= 0;
      rx_run  <= 0;
      rel_run <= 0;
    end else begin
      tx_run  <= tx_online ? tx_run + 32'd1 : 32'd0;
      // Later stages need the raw inputs and the earlier stage
      rx_run  <= (tx_online && rx_online && exp_tx) ? rx_run + 32'd1 : 32'd0;
      rel_run <= (tx_online && rx_online && exp_tx && exp_rx) ? rel_run + 32'd1 : 32'd0;
    end
  end

  // History for expected values
  always_ff @(posedge clk_wr) begin
    ustrm_h   <= {ustrm_h[2:1], ustrm};
    dstrm_d1  <= dstrm;
    tx_phy_d1 <= tx_phy;
    cnt_d1    <= rx_debug_status.count;
    bad_d1    <= exp_rx & !rx_phy.lane0[0];
    tx_cnt_d1 <= tx_debug_status.count;
    gen2_d1   <= m_gen2_mode;
  end

  ////////////////////////////////////////
  // Bring-up and gating

  a_tx_online: assert property (@(posedge clk_wr) disable iff (reset)
    tx_debug_status.tx_online_delay == exp_tx && rx_debug_status.tx_online_delay == exp_tx)
    else begin
      $error("Mismatch tx_online_delay: got %h/%h expected %h",
             $sampled(tx_debug_status.tx_online_delay),
             $sampled(rx_debug_status.tx_online_delay), $sampled(exp_tx));
      err_count++;
    end

  a_rx_online: assert property (@(posedge clk_wr) disable iff (reset)
    tx_debug_status.rx_online_delay == exp_rx && rx_debug_status.rx_online_delay == exp_rx)
    else begin
      $error("Mismatch rx_online_delay: got %h/%h expected %h",
             $sampled(tx_debug_status.rx_online_delay),
             $sampled(rx_debug_status.rx_online_delay), $sampled(exp_rx));
      err_count++;
    end

  // Strobe on every online beat, silent lanes otherwise
  a_tx_beat: assert property (@(posedge clk_wr) disable iff (reset)
    $past(exp_tx) ? tx_phy.lane0[0] : tx_phy == '0)
    else begin
      $error("Mismatch tx_phy: got %h expected strobe %h",
             $sampled(tx_phy), $past(exp_tx));
      err_count++;
    end

  a_dstrm_gated: assert property (@(posedge clk_wr) disable iff (reset)
    !exp_rel |-> dstrm == '0)
    else begin
      $error("Mismatch dstrm: got %h expected %h", $sampled(dstrm), 42'h0);
      err_count++;
    end

  ////////////////////////////////////////
  // Data path

  a_gen2_data: assert property (@(posedge clk_wr) disable iff (reset)
    ($past(m_gen2_mode) && $past(m_gen2_mode, 2) && exp_rel && $past(exp_rel)
      && $past(exp_rel, 2) && $past(rx_phy.lane0[0]))
    |-> dstrm == ustrm_h[2])
    else begin
      $error("Mismatch dstrm: got %h expected %h", $sampled(dstrm), $sampled(ustrm_h[2]));
      err_count++;
    end

  a_gen1_lane1: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(m_gen2_mode) |-> tx_phy.lane1 == '0)
    else begin
      $error("Mismatch tx_phy.lane1: got %h expected %h", $sampled(tx_phy.lane1), 40'h0);
      err_count++;
    end

  // Marker flips between low and high halves
  a_gen1_marker: assert property (@(posedge clk_wr) disable iff (reset)
    (!$past(m_gen2_mode) && !$past(m_gen2_mode, 2) && $past(exp_tx) && $past(exp_tx, 2))
    |-> tx_phy.lane0[lane_width_c-1] != tx_phy_d1.lane0[lane_width_c-1])
    else begin
      $error("Mismatch tx_phy marker: got %h expected %h",
             $sampled(tx_phy.lane0[lane_width_c-1]),
             !$sampled(tx_phy_d1.lane0[lane_width_c-1]));
      err_count++;
    end

  // Clean marker beat then clean second half
  a_gen1_data: assert property (@(posedge clk_wr) disable iff (reset)
    (!$past(m_gen2_mode) && !$past(m_gen2_mode, 2) && exp_rel && $past(exp_rel)
      && $past(exp_rx, 2) && $past(rx_phy.lane0[0]) && $past(rx_phy.lane0[0], 2)
      && !$past(rx_phy.lane0[lane_width_c-1]) && $past(rx_phy.lane0[lane_width_c-1], 2))
    |-> dstrm == ustrm_h[3])
    else begin
      $error("Mismatch dstrm: got %h expected %h", $sampled(dstrm), $sampled(ustrm_h[3]));
      err_count++;
    end

  ////////////////////////////////////////
  // Word and error counts

  // Sent count moves with each word closed on the lanes
  a_tx_count: assert property (@(posedge clk_wr) disable iff (reset)
    tx_debug_status.count == tx_cnt_d1 + {15'd0, tx_word_end})
    else begin
      $error("Mismatch tx_debug_status.count: got %h expected %h",
             $sampled(tx_debug_status.count),
             $sampled(tx_cnt_d1) + {15'd0, $sampled(tx_word_end)});
      err_count++;
    end

  a_strobe_hold: assert property (@(posedge clk_wr) disable iff (reset)
    (exp_rel && $past(exp_rel) && !$past(rx_phy.lane0[0])) |-> dstrm == dstrm_d1)
    else begin
      $error("Mismatch dstrm: got %h expected %h", $sampled(dstrm), $sampled(dstrm_d1));
      err_count++;
    end

  a_err_count: assert property (@(posedge clk_wr) disable iff (reset)
    rx_debug_status.count == cnt_d1 + {15'd0, bad_d1})
    else begin
      $error("Mismatch rx_debug_status.count: got %h expected %h",
             $sampled(rx_debug_status.count),
             $sampled(cnt_d1) + {15'd0, $sampled(bad_d1)});
      err_count++;
    end

endmodule

// File: lpif_slave_tb.sv
/*
  Testbench for lpif_slave_top, tx_phy looped back onto rx_phy
  The bound lpif_slave_checker does all value checks
  Corruption clears the strobe of single beats at random
*/
module lpif_slave_tb import lpif_slave_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  logic               clk_wr;
  logic               reset;
  logic               tx_online;
  logic               rx_online;
  logic               m_gen2_mode;
  lpif_delay_cfg_t    delay_cfg;
  lpif_stream_t       ustrm;
  lpif_phy_pair_t     rx_phy;
  lpif_phy_pair_t     tx_phy;
  lpif_stream_t       dstrm;
  lpif_debug_status_t tx_debug_status;
  lpif_debug_status_t rx_debug_status;
  // Clear the strobe of the current beat
  logic               corrupt;
  int unsigned        timeouts;

  bind lpif_slave_top lpif_slave_checker props_i (.*);

  lpif_slave_top dut (.*);

  initial clk_wr = 1'b0;
  always #5 clk_wr = ~clk_wr;

  // Lane loopback
  always_comb begin
    rx_phy = tx_phy;
    if (corrupt) begin
      rx_phy.lane0[0] = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Helpers

  function automatic logic [15:0] draw_delay();
    return 16'($urandom_range(8, 1));
  endfunction

  // Poll one online flag of tx_debug_status on falling edges
  task automatic wait_flag(input bit rx_side, input logic level, input string what);
    int n;
    n = 0;
    while ((rx_side ? tx_debug_status.rx_online_delay : tx_debug_status.tx_online_delay)
           !== level && n < 60) begin
      @(negedge clk_wr);
      n++;
    end
    if ((rx_side ? tx_debug_status.rx_online_delay : tx_debug_status.tx_online_delay)
        !== level) begin
      $display("ERROR: timed out waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic bring_up(input logic gen2);
    m_gen2_mode       = gen2;
    delay_cfg.delay_x = draw_delay();
    delay_cfg.delay_y = draw_delay();
    delay_cfg.delay_z = draw_delay();
    @(negedge clk_wr);
    tx_online = 1'b1;
    wait_flag(1'b0, 1'b1, "TX online");
    rx_online = 1'b1;
    wait_flag(1'b1, 1'b1, "RX online");
  endtask

  // Random words, each held for hold cycles, about one beat in 8 corrupted
  task automatic send_words(input int count, input int hold);
    logic [63:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd   = {$urandom, $urandom};
      ustrm = rnd[stream_width_c-1:0];
      for (int h = 0; h < hold; h++) begin
        corrupt = ($urandom_range(7, 0) == 0);
        @(negedge clk_wr);
      end
    end
    corrupt = 1'b0;
  endtask

  // Drop TX first, RX flag must follow
  task automatic shut_down();
    tx_online = 1'b0;
    wait_flag(1'b0, 1'b0, "TX offline");
    wait_flag(1'b1, 1'b0, "RX offline");
    rx_online = 1'b0;
    repeat (4) @(negedge clk_wr);
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(60645));
    reset       = 1'b1;
    tx_online   = 1'b0;
    rx_online   = 1'b0;
    m_gen2_mode = 1'b1;
    delay_cfg   = '0;
    ustrm       = '0;
    corrupt     = 1'b0;
    timeouts    = 0;
    repeat (4) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;

    // Gen2, one word per cycle
    bring_up(1'b1);
    send_words(60, 1);
    shut_down();

    // Gen1, words held two cycles
    bring_up(1'b0);
    send_words(40, 2);
    shut_down();

    $display("assertion errors: %0d, timeouts: %0d", dut.props_i.err_count, timeouts);
    if (dut.props_i.err_count == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: lpif_slave.f
lpif_slave_pkg.sv
lpif_auto_sync.sv
lpif_phy_tx.sv
lpif_phy_rx.sv
lpif_slave_top.sv
lpif_slave_properties.sv
lpif_slave_tb.sv

// File: Bender.yml
package:
  name: lpif_slave

sources:
  - lpif_slave_pkg.sv
  - lpif_auto_sync.sv
  - lpif_phy_tx.sv
  - lpif_phy_rx.sv
  - lpif_slave_top.sv
  - target: test
    files:
      - lpif_slave_properties.sv
      - lpif_slave_tb.sv
